// File: common/alu_params.svh
// ALU parameters
// Data width, width of the approximate adder segment and the
// carry-select group width shared by the execute stage and the adder

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// --------------------
// Datapath
// --------------------
`define ALU_XLEN    32              // RV32 data width

// --------------------
// Approximate adder
// --------------------
`define ALU_APX_LEN 8               // Multiple of 4, from 4 up to ALU_XLEN
`define ALU_GRP_LEN 4               // Carry-select group size

`endif

// File: common/rv_isa_pkg.sv
// RV32I ISA definitions
// Major opcodes, funct fields, the instruction word with its R-type and
// I-type views, and the ALU operation codes

package rv_isa_pkg;

    // --------------------
    // Major opcodes
    // --------------------
    localparam logic [6:0] OPC_OP     = 7'b01_100_11;   // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b00_100_11;   // Register-immediate
    localparam logic [6:0] OPC_AUIPC  = 7'b00_101_11;   // Add upper imm to pc

    localparam logic [6:0] F7_BASE = 7'b000_0000;       // ADD, SRL and the rest
    localparam logic [6:0] F7_ALT  = 7'b010_0000;       // SUB and SRA

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SR  = 3'b101;             // SRL or SRA

    // --------------------
    // Instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;                                // Also shamt slot
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;                               // Upper 7 bits act as funct7 on shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } rv_instr_u;

    // Low 3 bits follow funct3, bit 3 is the alternate funct7 form
    typedef enum logic [3:0] {
        ADD     = 4'b0000,
        SLL     = 4'b0001,
        SLT     = 4'b0010,
        SLTU    = 4'b0011,
        XOR     = 4'b0100,
        SRL     = 4'b0101,
        OR      = 4'b0110,
        AND     = 4'b0111,
        SUB     = 4'b1000,
        SRA     = 4'b1101,
        ILLEGAL = 4'b1111
    } alu_op_e;

endpackage

// File: common/approx_ctrl_pkg.sv
// Approximation control register
// Field layout of the 32-bit control word that sets the adder accuracy,
// and its value after reset

`include "alu_params.svh"

package approx_ctrl_pkg;

    // --------------------
    // Register layout
    // --------------------
    typedef struct packed {
        logic [`ALU_XLEN-4:0] error_ctrl;   // Bits 31:3, per-bit error enables
        logic [1:0]           circuit_sel;  // Bits 2:1, kept but only one circuit exists
        logic                 approx_en;    // Bit 0, 1 = approximate
    } approx_ctrl_t;

    // All zero means accurate mode
    localparam approx_ctrl_t APPROX_CTRL_RESET = '0;

endpackage

// File: common/alu_op_if.sv
// Decoder to execute bus
// Carries the decoded ALU operation and its two operands with a
// valid/ready handshake

`timescale 1ns/1ps
`include "alu_params.svh"

interface alu_op_if import rv_isa_pkg::*; ();

    logic                 valid;            // Request present
    logic                 ready;            // Execute can take it
    alu_op_e              op;               // Decoded operation
    logic [`ALU_XLEN-1:0] operand_1;        // rs1 or pc
    logic [`ALU_XLEN-1:0] operand_2;        // rs2, imm or shamt
    logic                 is_imm_shift;     // Shift amount from the instruction

    // --------------------
    // Views
    // --------------------
    modport decoder (
        output valid, op, operand_1, operand_2, is_imm_shift
    );

    modport execute (
        input  valid, op, operand_1, operand_2, is_imm_shift,
        output ready
    );

endinterface

// File: hdl/alu_decoder.sv
// ALU decoder
// Maps opcode, funct3 and funct7 of an RV32I instruction to an ALU
// operation and picks the two operands for OP, OP_IMM and AUIPC

`timescale 1ns/1ps
`include "alu_params.svh"

module alu_decoder import rv_isa_pkg::*; (
    input  logic                 in_valid,
    input  rv_instr_u            instr,
    input  logic [`ALU_XLEN-1:0] pc,
    input  logic [`ALU_XLEN-1:0] rs1,
    input  logic [`ALU_XLEN-1:0] rs2,
    input  logic [`ALU_XLEN-1:0] imm,
    alu_op_if.decoder            op_bus
);

    logic [6:0] imm_hi;                                 // funct7 slot of a shift-immediate

    assign imm_hi       = instr.i.imm[11:5];
    assign op_bus.valid = in_valid;                     // Pass-through, no buffering

    always_comb begin
        op_bus.op           = ILLEGAL;
        op_bus.operand_1    = rs1;
        op_bus.operand_2    = rs2;
        op_bus.is_imm_shift = 1'b0;

        case (instr.r.opcode)
            OPC_OP: begin
                if (instr.r.funct7 == F7_BASE) begin
                    op_bus.op = alu_op_e'({1'b0, instr.r.funct3});
                end else if (instr.r.funct7 == F7_ALT &&
                             (instr.r.funct3 == F3_ADD || instr.r.funct3 == F3_SR)) begin
                    op_bus.op = alu_op_e'({1'b1, instr.r.funct3});     // SUB or SRA
                end
            end

            OPC_OP_IMM: begin
                op_bus.operand_2 = imm;
                case (instr.i.funct3)
                    F3_SLL: begin
                        op_bus.is_imm_shift = 1'b1;
                        if (imm_hi == F7_BASE) begin
                            op_bus.op = SLL;
                        end
                    end
                    F3_SR: begin
                        op_bus.is_imm_shift = 1'b1;
                        if (imm_hi == F7_BASE) begin
                            op_bus.op = SRL;
                        end else if (imm_hi == F7_ALT) begin
                            op_bus.op = SRA;
                        end
                    end
                    default: op_bus.op = alu_op_e'({1'b0, instr.i.funct3}); // No SUBI
                endcase

                // Shamt taken from the instruction, upper imm bits dropped
                if (op_bus.is_imm_shift) begin
                    op_bus.operand_2 = {{(`ALU_XLEN-5){1'b0}}, instr.i.imm[4:0]};
                end
            end

            OPC_AUIPC: begin
                op_bus.op        = ADD;
                op_bus.operand_1 = pc;
                op_bus.operand_2 = imm;                 // Already shifted by the imm generator
            end

            default: op_bus.op = ILLEGAL;
        endcase
    end

endmodule

// File: approx_adder/error_cfg_rca.sv
// Error-configurable ripple-carry adder
// Chain of full-adder cells, each with its own error enable. An enabled
// cell is exact; a disabled cell drops b&cin from its carry and ORs cin
// into its sum

`timescale 1ns/1ps

module error_cfg_rca #(
    parameter int LEN = 4                       // Number of cells
) (
    input  logic [LEN-1:0] er,                  // 1 = exact cell
    input  logic [LEN-1:0] a,
    input  logic [LEN-1:0] b,
    input  logic           cin,
    output logic [LEN-1:0] sum,
    output logic           cout
);

    logic [LEN:0] carry;                        // Ripple chain

    assign carry[0] = cin;

    for (genvar k = 0; k < LEN; k++) begin : g_cell
        logic p;                                // Propagate

        assign p = a[k] ^ b[k];

        // Approximate sum saturates to 1 when cin is set
        assign sum[k] = er[k] ? (p ^ carry[k]) : (p | carry[k]);

        // b&cin term only when the cell is exact
        assign carry[k+1] = (er[k] & b[k] & carry[k]) | (a[k] & (b[k] | carry[k]));
    end

    assign cout = carry[LEN];

endmodule

// File: approx_adder/approx_adder.sv
// Segmented carry-select adder
// Low group is a plain error-configurable ripple. Every further group
// precomputes its sum for carry-in 0, adds 1 for carry-in 1 and picks
// one by the carry of the group below. Groups under ALU_APX_LEN take
// the error enables, the rest are tied exact

`timescale 1ns/1ps
`include "alu_params.svh"

module approx_adder (
    input  logic [`ALU_APX_LEN-1:0] er,             // Per-bit enables of the low segment
    input  logic [`ALU_XLEN-1:0]    a,
    input  logic [`ALU_XLEN-1:0]    b,
    input  logic                    cin,
    output logic [`ALU_XLEN-1:0]    sum,
    output logic                    cout
);

    localparam int GRP  = `ALU_GRP_LEN;
    localparam int NGRP = `ALU_XLEN / `ALU_GRP_LEN;

    logic [NGRP-1:0] grp_c;                         // Carry out of each group

    // --------------------
    // Low group
    // --------------------
    error_cfg_rca #(
        .LEN (GRP)
    ) u_rca_low (
        .er   (er[GRP-1:0]),
        .a    (a[GRP-1:0]),
        .b    (b[GRP-1:0]),
        .cin  (cin),                                // Real carry in, SUB uses it
        .sum  (sum[GRP-1:0]),
        .cout (grp_c[0])
    );

    // --------------------
    // Carry-select groups
    // --------------------
    for (genvar g = 1; g < NGRP; g++) begin : g_grp
        localparam int LO = g * GRP;
        localparam int HI = LO + GRP - 1;

        logic [GRP-1:0] grp_er;                     // Enables for this group
        logic [GRP-1:0] sum0;                       // Sum assuming carry in 0
        logic [GRP-1:0] sum1;                       // Sum assuming carry in 1
        logic           ha_c;                       // Half adder carry
        logic           rca_c;                      // Ripple carry out
        logic           inc_c;                      // Increment overflow

        if (LO < `ALU_APX_LEN) begin : g_apx
            assign grp_er = er[HI:LO];
        end else begin : g_exact
            assign grp_er = '1;                     // Upper segment always exact
        end

        // Single cell with cin 0 is a half adder whatever its enable
        error_cfg_rca #(
            .LEN (1)
        ) u_ha (
            .er   (grp_er[0]),
            .a    (a[LO]),
            .b    (b[LO]),
            .cin  (1'b0),
            .sum  (sum0[0]),
            .cout (ha_c)
        );

        error_cfg_rca #(
            .LEN (GRP - 1)
        ) u_rca (
            .er   (grp_er[GRP-1:1]),
            .a    (a[HI:LO+1]),
            .b    (b[HI:LO+1]),
            .cin  (ha_c),
            .sum  (sum0[GRP-1:1]),
            .cout (rca_c)
        );

        // +1 unit, carries out only when sum0 is all ones
        assign {inc_c, sum1} = {1'b0, sum0} + {{GRP{1'b0}}, 1'b1};

        // Select on the carry from below
        assign sum[HI:LO] = grp_c[g-1] ? sum1 : sum0;
        assign grp_c[g]   = grp_c[g-1] ? (rca_c | inc_c) : rca_c;
    end

    assign cout = grp_c[NGRP-1];

endmodule

// File: hdl/alu_execute.sv
// ALU execute stage
// Runs the decoded operation through the shared approximate adder or the
// shift, compare and logic paths, and holds the result in an output
// register with a valid/ready handshake

`timescale 1ns/1ps
`include "alu_params.svh"

module alu_execute import rv_isa_pkg::*, approx_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  approx_ctrl_t         approx_ctrl,       // Adder accuracy setting
    alu_op_if.execute            op_bus,
    input  logic                 out_ready,
    output logic                 out_valid,
    output logic [`ALU_XLEN-1:0] result,
    output logic                 illegal
);

    logic [`ALU_XLEN-1:0]    add_b;                 // Second adder input
    logic                    add_cin;
    logic [`ALU_XLEN-1:0]    add_sum;
    logic [`ALU_APX_LEN-1:0] add_er;                // Effective error enables
    logic [4:0]              shamt;
    logic [`ALU_XLEN-1:0]    alu_res;               // Combinational result
    logic                    take;                  // Transfer this cycle

    // --------------------
    // Adder setup
    // --------------------
    assign add_cin = (op_bus.op == SUB);
    assign add_b   = add_cin ? ~op_bus.operand_2 : op_bus.operand_2;   // a + ~b + 1

    // Accurate mode forces every enable high
    assign add_er = approx_ctrl.error_ctrl[`ALU_APX_LEN-1:0] |
                    {`ALU_APX_LEN{~approx_ctrl.approx_en}};

    approx_adder u_adder (
        .er   (add_er),
        .a    (op_bus.operand_1),
        .b    (add_b),
        .cin  (add_cin),
        .sum  (add_sum),
        .cout ()                                    // Carry not needed, SLTU compares directly
    );

    // --------------------
    // Result select
    // --------------------
    assign shamt = op_bus.operand_2[4:0];           // RV32 uses 5 bits only

    always_comb begin
        case (op_bus.op)
            ADD, SUB: alu_res = add_sum;
            SLL:      alu_res = op_bus.operand_1 << shamt;
            SRL:      alu_res = op_bus.operand_1 >> shamt;
            SRA:      alu_res = $signed(op_bus.operand_1) >>> shamt;
            SLT:      alu_res = {{(`ALU_XLEN-1){1'b0}},
                                 $signed(op_bus.operand_1) < $signed(op_bus.operand_2)};
            SLTU:     alu_res = {{(`ALU_XLEN-1){1'b0}}, op_bus.operand_1 < op_bus.operand_2};
            XOR:      alu_res = op_bus.operand_1 ^ op_bus.operand_2;
            OR:       alu_res = op_bus.operand_1 | op_bus.operand_2;
            AND:      alu_res = op_bus.operand_1 & op_bus.operand_2;
            default:  alu_res = '0;                 // Illegal returns zero
        endcase
    end

    // --------------------
    // Output register
    // --------------------
    assign op_bus.ready = ~out_valid | out_ready;   // Free or draining
    assign take         = op_bus.valid & op_bus.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (op_bus.ready) begin
            out_valid <= op_bus.valid;              // Drops when drained with no new request
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result  <= alu_res;                     // Held while stalled
            illegal <= (op_bus.op == ILLEGAL);
        end
    end

endmodule

// File: hdl/alu_top.sv
// RV32I integer execute stage, top level
// Decodes a request, runs it through the execute stage with its
// approximate adder and returns one registered result. Also holds the
// approximation control register

`timescale 1ns/1ps
`include "alu_params.svh"

module alu_top import approx_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // Request side
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`ALU_XLEN-1:0] instr,
    input  logic [`ALU_XLEN-1:0] pc,
    input  logic [`ALU_XLEN-1:0] rs1,
    input  logic [`ALU_XLEN-1:0] rs2,
    input  logic [`ALU_XLEN-1:0] imm,
    // Result side
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [`ALU_XLEN-1:0] result,
    output logic                 illegal,
    // Control register write
    input  logic                 csr_we,
    input  logic [`ALU_XLEN-1:0] csr_wdata
);

    approx_ctrl_t approx_ctrl;                      // Accuracy setting

    alu_op_if op_bus ();

    // --------------------
    // Control register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            approx_ctrl <= APPROX_CTRL_RESET;       // Accurate after reset
        end else if (csr_we) begin
            approx_ctrl <= approx_ctrl_t'(csr_wdata);
        end
    end

    assign in_ready = op_bus.ready;

    // --------------------
    // Stages
    // --------------------
    alu_decoder u_decoder (
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm),
        .op_bus   (op_bus.decoder)
    );

    alu_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .approx_ctrl (approx_ctrl),
        .op_bus      (op_bus.execute),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .result      (result),
        .illegal     (illegal)
    );

endmodule

// File: testbench/tb_alu_top.sv
// Testbench for the RV32I execute stage
// Reads requests and expected responses from the vector file, drives them
// with random idle gaps and out_ready stalls, and checks every result in
// request order

`timescale 1ns/1ps
`include "alu_params.svh"

module tb_alu_top;

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 200;                   // Cycles allowed per wait

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    logic [`ALU_XLEN-1:0] instr;
    logic [`ALU_XLEN-1:0] pc;
    logic [`ALU_XLEN-1:0] rs1;
    logic [`ALU_XLEN-1:0] rs2;
    logic [`ALU_XLEN-1:0] imm;
    logic                 out_valid;
    logic                 out_ready;
    logic [`ALU_XLEN-1:0] result;
    logic                 illegal;
    logic                 csr_we;
    logic [`ALU_XLEN-1:0] csr_wdata;

    // Vector table
    logic [31:0] v_ctrl   [MAX_VEC];
    logic [31:0] v_instr  [MAX_VEC];
    logic [31:0] v_pc     [MAX_VEC];
    logic [31:0] v_rs1    [MAX_VEC];
    logic [31:0] v_rs2    [MAX_VEC];
    logic [31:0] v_imm    [MAX_VEC];
    logic [31:0] v_result [MAX_VEC];
    logic        v_ill    [MAX_VEC];
    string       v_name   [MAX_VEC];

    int          n_vec;
    int          pending[$];                        // Accepted but not yet returned
    int          n_checked;
    int          n_passed;
    int          n_failed;
    int          n_errors;                          // Any failed check
    bit          load_ok;
    bit          hung;
    bit          stalled;
    logic [31:0] held_result;
    logic        held_illegal;
    logic        exp_ready;                         // Input side open unless a result waits
    logic [31:0] last_ctrl;                         // Control value in the DUT
    int unsigned seed_val;

    alu_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr     (instr),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .illegal   (illegal),
        .csr_we    (csr_we),
        .csr_wdata (csr_wdata)
    );

    // --------------------
    // Clock and stalls
    // --------------------
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    always @(negedge clk) begin
        if (rst) begin
            out_ready = 1'b1;
        end else begin
            out_ready = ($urandom % 4) != 0;        // Stall about one cycle in four
        end
    end

    // --------------------
    // Vector loading
    // --------------------
    task automatic load_vectors();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("testbench/alu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file testbench/alu_vectors.txt");
            load_ok = 1'b0;
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;                           // Blank or column notes
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %s", v_ctrl[n_vec],
                          v_instr[n_vec], v_pc[n_vec], v_rs1[n_vec], v_rs2[n_vec],
                          v_imm[n_vec], v_result[n_vec], v_ill[n_vec], v_name[n_vec]);
            if (cnt == 9) begin
                n_vec++;
            end else begin
                $display("malformed line in the vector file: %s", line);
                load_ok = 1'b0;
            end
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("the vector file holds no requests");
            load_ok = 1'b0;
        end
    endtask

    // --------------------
    // Driver
    // --------------------
    task automatic send_request(input int idx);
        int waited;
        bit accepted;
        repeat ($urandom % 3) @(negedge clk);       // Idle gap
        if (v_ctrl[idx] !== last_ctrl) begin
            csr_we    = 1'b1;                       // Write lands one edge before the request
            csr_wdata = v_ctrl[idx];
            @(negedge clk);
            csr_we    = 1'b0;
            last_ctrl = v_ctrl[idx];
        end
        in_valid = 1'b1;
        instr    = v_instr[idx];
        pc       = v_pc[idx];
        rs1      = v_rs1[idx];
        rs2      = v_rs2[idx];
        imm      = v_imm[idx];
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            if (in_ready) begin
                accepted = 1'b1;
                pending.push_back(idx);
            end
            waited++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        if (!accepted) begin
            $display("timeout: request %0d %s not accepted within %0d cycles",
                     idx, v_name[idx], TIMEOUT);
            hung = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending.size() > 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() > 0) begin
            $display("timeout: %0d results still missing after %0d cycles",
                     pending.size(), TIMEOUT);
            hung = 1'b1;
        end
    endtask

    // --------------------
    // Checker
    // --------------------
    task automatic check_result(input int idx);
        bit ok;
        ok = 1'b1;
        assert (result === v_result[idx]) else begin
            $display("[ERROR] %0t ns %s: result expected %h got %h",
                     $time, v_name[idx], v_result[idx], result);
            ok = 1'b0;
        end
        assert (illegal === v_ill[idx]) else begin
            $display("[ERROR] %0t ns %s: illegal expected %b got %b",
                     $time, v_name[idx], v_ill[idx], illegal);
            ok = 1'b0;
        end
        n_checked++;
        if (ok) begin
            n_passed++;
        end else begin
            n_failed++;
            n_errors++;
        end
        $display("test %0d %s %s", idx, v_name[idx], ok ? "passed" : "failed");
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // Back-pressure closes the request side, otherwise it stays open
            exp_ready = !(out_valid && !out_ready);
            assert (in_ready === exp_ready) else begin
                $display("[ERROR] %0t ns in_ready expected %b got %b",
                         $time, exp_ready, in_ready);
                n_errors++;
            end
            if (stalled && out_valid) begin         // Output must hold while stalled
                assert (result === held_result) else begin
                    $display("[ERROR] %0t ns result expected %h got %h while stalled",
                             $time, held_result, result);
                    n_errors++;
                end
                assert (illegal === held_illegal) else begin
                    $display("[ERROR] %0t ns illegal expected %b got %b while stalled",
                             $time, held_illegal, illegal);
                    n_errors++;
                end
            end
            if (out_valid && out_ready) begin
                assert (pending.size() > 0) else begin
                    $display("a result came out at %0t ns with no request pending", $time);
                    n_errors++;
                end
                if (pending.size() > 0) begin
                    check_result(pending.pop_front());
                end
            end
            stalled      = out_valid && !out_ready;
            held_result  = result;
            held_illegal = illegal;
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        $timeformat(-9, 0, "", 0);
        rst       = 1'b1;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        out_ready = 1'b1;
        csr_we    = 1'b0;
        csr_wdata = '0;
        last_ctrl = '0;                             // Reset value of the control register
        n_vec     = 0;
        n_checked = 0;
        n_passed  = 0;
        n_failed  = 0;
        n_errors  = 0;
        load_ok   = 1'b1;
        hung      = 1'b0;
        stalled   = 1'b0;
        seed_val  = $urandom(32'hb187);

        load_vectors();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (load_ok) begin
            for (int i = 0; i < n_vec && !hung; i++) begin
                send_request(i);
            end
            if (!hung) begin
                wait_drain();
            end
        end

        $display("tests %0d, checked %0d, passed %0d, failed %0d, errors %0d",
                 n_vec, n_checked, n_passed, n_failed, n_errors);
        if (load_ok && !hung && n_errors == 0 && n_checked == n_vec) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/alu_vectors.txt
# ctrl     instr    pc       rs1      rs2      imm      result   ill name
# all hex, result and ill are the expected response of the stage
00000000 002081b3 00000000 7fffffff 00000001 00000000 80000000 0 add_ovf
00000000 002081b3 00000000 ffffffff 00000002 00000000 00000001 0 add_wrap
00000000 402081b3 00000000 00000005 00000007 00000000 fffffffe 0 sub_neg
00000000 402081b3 00000000 80000000 00000001 00000000 7fffffff 0 sub_ovf
00000000 fff08193 00000000 00001000 00000000 ffffffff 00000fff 0 addi_neg
00000000 12345197 80000f00 00000000 00000000 12345000 92345f00 0 auipc
00000000 12345197 f0000004 00000000 00000000 12345000 02345004 0 auipc_wrap
00000000 002091b3 00000000 8000000f 00000024 00000000 000000f0 0 sll
00000000 0020d1b3 00000000 80000000 0000001f 00000000 00000001 0 srl
00000000 4020d1b3 00000000 80000000 00000004 00000000 f8000000 0 sra
00000000 00409193 00000000 12345678 00000000 00000004 23456780 0 slli
00000000 0080d193 00000000 f0000000 00000000 00000008 00f00000 0 srli
00000000 41f0d193 00000000 80000000 00000000 0000041f ffffffff 0 srai
00000000 0020a1b3 00000000 80000000 7fffffff 00000000 00000001 0 slt_min
00000000 0020b1b3 00000000 80000000 7fffffff 00000000 00000000 0 sltu_min
00000000 0020a1b3 00000000 ffffffff 00000000 00000000 00000001 0 slt_neg
00000000 0020b1b3 00000000 00000000 ffffffff 00000000 00000001 0 sltu_max
00000000 fff0a193 00000000 fffffffe 00000000 ffffffff 00000001 0 slti
00000000 0020c1b3 00000000 f0f0f0f0 ff00ff00 00000000 0ff00ff0 0 xor
00000000 0020e1b3 00000000 f0f0f0f0 0f0f0000 00000000 fffff0f0 0 or
00000000 0020f1b3 00000000 f0f0f0f0 ff00ff00 00000000 f000f000 0 and
00000000 0ff0c193 00000000 12345678 00000000 000000ff 12345687 0 xori
00000000 123451b7 00000000 11111111 22222222 12345000 00000000 1 ill_lui
00000000 022081b3 00000000 00000006 00000007 00000000 00000000 1 ill_mul
00000000 402091b3 00000000 00000001 00000002 00000000 00000000 1 ill_f7_sll
00000000 40409193 00000000 00000001 00000000 00000404 00000000 1 ill_slli
00000000 0280d193 00000000 80000000 00000000 00000028 00000000 1 ill_srli
00000001 002081b3 00000000 000012f3 00003415 00000000 000047e6 0 apx_add
00000001 402081b3 00000000 00000010 00000001 00000000 ffffffef 0 apx_sub
00000021 002081b3 00000000 000012f3 00003415 00000000 000047ea 0 apx_bit2
00000007 002081b3 00000000 000012f3 00003415 00000000 000047e6 0 apx_csel
fffff801 002081b3 00000000 000012f3 00003415 00000000 000047e6 0 apx_hi_ctrl
000007f9 002081b3 00000000 000012f3 00003415 00000000 00004708 0 apx_all_en
00000000 002081b3 00000000 000012f3 00003415 00000000 00004708 0 acc_again

// File: sources.f
+incdir+common
common/rv_isa_pkg.sv
common/approx_ctrl_pkg.sv
common/alu_op_if.sv
hdl/alu_decoder.sv
approx_adder/error_cfg_rca.sv
approx_adder/approx_adder.sv
hdl/alu_execute.sv
hdl/alu_top.sv
testbench/tb_alu_top.sv
